//--- source/dtm_pkg.sv
// Shared DTM types: TAP states, IR codes, DMI word layout, bus structs, DTMCS fields

package dtm_pkg;

    //------------------------------------------------------------------
    // TAP controller
    //------------------------------------------------------------------
    typedef enum logic [3:0] {
        ts_reset    = 4'h0, // Test-Logic-Reset
        ts_idle     = 4'h1, // Run-Test/Idle
        ts_sel_dr   = 4'h2,
        ts_cap_dr   = 4'h3,
        ts_shift_dr = 4'h4,
        ts_exit1_dr = 4'h5,
        ts_pause_dr = 4'h6,
        ts_exit2_dr = 4'h7,
        ts_upd_dr   = 4'h8,
        ts_sel_ir   = 4'h9,
        ts_cap_ir   = 4'ha,
        ts_shift_ir = 4'hb,
        ts_exit1_ir = 4'hc,
        ts_pause_ir = 4'hd,
        ts_exit2_ir = 4'he,
        ts_upd_ir   = 4'hf
    } tap_state_e;

    localparam int ir_width = 5;

    // Unlisted codes select BYPASS
    typedef enum logic [ir_width-1:0] {
        ir_idcode = 5'h01,
        ir_dtmcs  = 5'h10,
        ir_dmi    = 5'h11,
        ir_bypass = 5'h1f
    } ir_code_e;

    //------------------------------------------------------------------
    // DMI word, 41 bits, op/resp in the low bits
    //------------------------------------------------------------------
    localparam int dmi_abits      = 7;
    localparam int dmi_word_width = 41;

    localparam logic [1:0] dmi_op_nop      = 2'd0;
    localparam logic [1:0] dmi_op_write    = 2'd2; // Read is 1
    localparam logic [1:0] dmi_resp_ok     = 2'd0;
    localparam logic [1:0] dmi_resp_failed = 2'd2;
    localparam logic [1:0] dmi_resp_busy   = 2'd3;

    typedef struct packed {
        logic [dmi_abits-1:0] addr;
        logic [31:0]          data;
        logic [1:0]           op;
    } dmi_req_t;

    typedef struct packed {
        logic [dmi_abits-1:0] addr;
        logic [31:0]          data;
        logic [1:0]           resp;
    } dmi_resp_t;

    // Request view at Update-DR, response view at Capture-DR
    typedef union packed {
        dmi_req_t  req;
        dmi_resp_t resp;
    } dmi_word_u;

    //------------------------------------------------------------------
    // TAP to data register interface
    //------------------------------------------------------------------
    typedef struct packed {
        logic capture;
        logic shift;
        logic update;
        logic tdi;
    } dr_ctl_t;

    typedef struct packed {
        logic sel_idcode;
        logic sel_dtmcs;
        logic sel_dmi;
        logic sel_bypass;
    } dr_sel_t;

    // Debug module bus
    typedef struct packed {
        logic                 req;
        logic                 rw;    // 1 = write
        logic [dmi_abits-1:0] addr;
        logic [31:0]          wdata;
    } dmbus_req_t;

    typedef struct packed {
        logic [31:0] rdata;
        logic        ack;   // One-cycle pulse
        logic        err;
    } dmbus_rsp_t;

    // DTMCS fields
    localparam logic [3:0] dtmcs_version          = 4'd1;
    localparam int         dtmcs_dmireset_bit     = 16;
    localparam int         dtmcs_dmihardreset_bit = 17;

endpackage

//--- source/jtag_tap_ctrl.sv
// TAP state machine, instruction register, DR select decode and strobes, TDO output
`timescale 1ns/1ps

module jtag_tap_ctrl
(
    input  logic             tck,           // JTAG clock
    input  logic             res_tap_async, // TAP reset, active high
    input  logic             tms,
    input  logic             tdi,
    input  logic             tdo_regs,      // Serial out of BYPASS/IDCODE/DTMCS
    input  logic             tdo_dmi,       // Serial out of DMI
    output dtm_pkg::dr_ctl_t dr_ctl,
    output dtm_pkg::dr_sel_t dr_sel,
    output logic             tdo_d,
    output logic             tdo_e
);

    dtm_pkg::tap_state_e             state;
    dtm_pkg::tap_state_e             state_next;
    logic [dtm_pkg::ir_width-1:0]    ir_shift;  // IR shift stage
    logic [dtm_pkg::ir_width-1:0]    ir_reg;    // Current instruction

    //------------------------------------------------------------------
    // TAP state machine
    //------------------------------------------------------------------
    always_ff @(posedge tck or posedge res_tap_async)
    begin
        if (res_tap_async)
            state <= dtm_pkg::ts_reset;
        else
            state <= state_next;
    end

    always_comb
    begin
        case (state)
            dtm_pkg::ts_reset:    state_next = tms ? dtm_pkg::ts_reset   : dtm_pkg::ts_idle;
            dtm_pkg::ts_idle:     state_next = tms ? dtm_pkg::ts_sel_dr  : dtm_pkg::ts_idle;
            // DR column
            dtm_pkg::ts_sel_dr:   state_next = tms ? dtm_pkg::ts_sel_ir  : dtm_pkg::ts_cap_dr;
            dtm_pkg::ts_cap_dr:   state_next = tms ? dtm_pkg::ts_exit1_dr : dtm_pkg::ts_shift_dr;
            dtm_pkg::ts_shift_dr: state_next = tms ? dtm_pkg::ts_exit1_dr : dtm_pkg::ts_shift_dr;
            dtm_pkg::ts_exit1_dr: state_next = tms ? dtm_pkg::ts_upd_dr  : dtm_pkg::ts_pause_dr;
            dtm_pkg::ts_pause_dr: state_next = tms ? dtm_pkg::ts_exit2_dr : dtm_pkg::ts_pause_dr;
            dtm_pkg::ts_exit2_dr: state_next = tms ? dtm_pkg::ts_upd_dr  : dtm_pkg::ts_shift_dr;
            dtm_pkg::ts_upd_dr:   state_next = tms ? dtm_pkg::ts_sel_dr  : dtm_pkg::ts_idle;
            // IR column
            dtm_pkg::ts_sel_ir:   state_next = tms ? dtm_pkg::ts_reset   : dtm_pkg::ts_cap_ir;
            dtm_pkg::ts_cap_ir:   state_next = tms ? dtm_pkg::ts_exit1_ir : dtm_pkg::ts_shift_ir;
            dtm_pkg::ts_shift_ir: state_next = tms ? dtm_pkg::ts_exit1_ir : dtm_pkg::ts_shift_ir;
            dtm_pkg::ts_exit1_ir: state_next = tms ? dtm_pkg::ts_upd_ir  : dtm_pkg::ts_pause_ir;
            dtm_pkg::ts_pause_ir: state_next = tms ? dtm_pkg::ts_exit2_ir : dtm_pkg::ts_pause_ir;
            dtm_pkg::ts_exit2_ir: state_next = tms ? dtm_pkg::ts_upd_ir  : dtm_pkg::ts_shift_ir;
            dtm_pkg::ts_upd_ir:   state_next = tms ? dtm_pkg::ts_sel_dr  : dtm_pkg::ts_idle;
            default:              state_next = dtm_pkg::ts_reset;
        endcase
    end

    //------------------------------------------------------------------
    // Instruction register
    //------------------------------------------------------------------
    always_ff @(posedge tck)
    begin
        if (state == dtm_pkg::ts_cap_ir)
            ir_shift <= ir_reg;                       // Capture returns current code
        else if (state == dtm_pkg::ts_shift_ir)
            ir_shift <= {tdi, ir_shift[dtm_pkg::ir_width-1:1]}; // LSB first
    end

    always_ff @(posedge tck or posedge res_tap_async)
    begin
        if (res_tap_async)
            ir_reg <= dtm_pkg::ir_idcode;
        else if (state == dtm_pkg::ts_reset)
            ir_reg <= dtm_pkg::ir_idcode;             // Test-Logic-Reset reload
        else if (state == dtm_pkg::ts_upd_ir)
            ir_reg <= ir_shift;
    end

    // One-hot register select
    always_comb
    begin
        dr_sel = '0;
        case (ir_reg)
            dtm_pkg::ir_idcode: dr_sel.sel_idcode = 1'b1;
            dtm_pkg::ir_dtmcs:  dr_sel.sel_dtmcs  = 1'b1;
            dtm_pkg::ir_dmi:    dr_sel.sel_dmi    = 1'b1;
            default:            dr_sel.sel_bypass = 1'b1; // 0x1f and unused codes
        endcase
    end

    // DR strobes, one TCK each; receivers combine with dr_sel
    assign dr_ctl.capture = (state == dtm_pkg::ts_cap_dr);
    assign dr_ctl.shift   = (state == dtm_pkg::ts_shift_dr);
    assign dr_ctl.update  = (state == dtm_pkg::ts_upd_dr);
    assign dr_ctl.tdi     = tdi;

    //------------------------------------------------------------------
    // TDO on falling TCK
    //------------------------------------------------------------------
    always_ff @(negedge tck or posedge res_tap_async)
    begin
        if (res_tap_async)
        begin
            tdo_d <= 1'b1;
            tdo_e <= 1'b0;
        end
        else if (state == dtm_pkg::ts_shift_ir)
        begin
            tdo_d <= ir_shift[0];
            tdo_e <= 1'b1;
        end
        else if (state == dtm_pkg::ts_shift_dr)
        begin
            tdo_d <= dr_sel.sel_dmi ? tdo_dmi : tdo_regs;
            tdo_e <= 1'b1;
        end
        else
        begin
            tdo_d <= 1'b1;                            // Idle level
            tdo_e <= 1'b0;
        end
    end

endmodule

//--- source/dtm_regs.sv
// BYPASS, IDCODE and DTMCS data registers with the DMI reset pulses
`timescale 1ns/1ps

module dtm_regs
#(
    parameter logic [31:0] idcode_value = 32'h1000_0a6d,
    parameter logic [2:0]  idle_hint    = 3'd5   // Run-Test/Idle cycles hint
)
(
    input  logic             tck,
    input  logic             res_tap_async,
    input  dtm_pkg::dr_ctl_t dr_ctl,
    input  dtm_pkg::dr_sel_t dr_sel,
    input  logic [1:0]       dmistat,      // Sticky DMI status
    output logic             tdo_regs,
    output logic             dmireset,     // Clear sticky status
    output logic             dmihardreset  // Clear DMI logic
);

    logic        bypass_reg;
    logic [31:0] idcode_sr;
    logic [31:0] dtmcs_sr;
    logic [31:0] dtmcs_word;
    logic        dtmcs_upd;

    //------------------------------------------------------------------
    // BYPASS and IDCODE
    //------------------------------------------------------------------
    always_ff @(posedge tck or posedge res_tap_async)
    begin
        if (res_tap_async)
            bypass_reg <= 1'b0;
        else if (dr_sel.sel_bypass)
        begin
            if (dr_ctl.capture)
                bypass_reg <= 1'b0;          // Fixed zero capture
            else if (dr_ctl.shift)
                bypass_reg <= dr_ctl.tdi;    // One-bit delay path
        end
    end

    always_ff @(posedge tck)
    begin
        if (dr_sel.sel_idcode && dr_ctl.capture)
            idcode_sr <= idcode_value;
        else if (dr_sel.sel_idcode && dr_ctl.shift)
            idcode_sr <= {dr_ctl.tdi, idcode_sr[31:1]};
    end

    //------------------------------------------------------------------
    // DTMCS
    //------------------------------------------------------------------
    // Reset request bits read as zero
    assign dtmcs_word = {14'd0,
                         1'b0,                            // dmihardreset
                         1'b0,                            // dmireset
                         1'b0,
                         idle_hint,                       // 14:12
                         dmistat,                         // 11:10
                         6'(dtm_pkg::dmi_abits),          // 9:4
                         dtm_pkg::dtmcs_version};         // 3:0

    always_ff @(posedge tck)
    begin
        if (dr_sel.sel_dtmcs && dr_ctl.capture)
            dtmcs_sr <= dtmcs_word;
        else if (dr_sel.sel_dtmcs && dr_ctl.shift)
            dtmcs_sr <= {dr_ctl.tdi, dtmcs_sr[31:1]};
    end

    assign dtmcs_upd = dr_sel.sel_dtmcs & dr_ctl.update;

    // Registered pulses, one TCK after Update-DR
    always_ff @(posedge tck or posedge res_tap_async)
    begin
        if (res_tap_async)
        begin
            dmireset     <= 1'b0;
            dmihardreset <= 1'b0;
        end
        else
        begin
            dmireset     <= dtmcs_upd & dtmcs_sr[dtm_pkg::dtmcs_dmireset_bit];
            dmihardreset <= dtmcs_upd & dtmcs_sr[dtm_pkg::dtmcs_dmihardreset_bit];
        end
    end

    // Serial out of whichever register is selected
    always_comb
    begin
        if (dr_sel.sel_idcode)
            tdo_regs = idcode_sr[0];
        else if (dr_sel.sel_dtmcs)
            tdo_regs = dtmcs_sr[0];
        else
            tdo_regs = bypass_reg;
    end

endmodule

//--- source/dmi_access.sv
// DMI shift register, sticky status, command tracking and debug-module bus master
`timescale 1ns/1ps

module dmi_access
(
    input  logic                tck,
    input  logic                res_tap_async,
    input  dtm_pkg::dr_ctl_t    dr_ctl,
    input  dtm_pkg::dr_sel_t    dr_sel,
    input  logic                dmireset,      // Clear sticky status
    input  logic                dmihardreset,  // Synchronous clear of all DMI state
    output logic [1:0]          dmistat,
    output logic                tdo_dmi,
    output dtm_pkg::dmbus_req_t dmbus_req,
    input  dtm_pkg::dmbus_rsp_t dmbus_rsp
);

    dtm_pkg::dmi_word_u                dmi_sr;     // Shifted DMI word
    dtm_pkg::dmi_resp_t                rsp_latch;  // Result of the last access
    dtm_pkg::dmi_resp_t                cap_word;   // Value for Capture-DR
    logic [1:0]                        status;     // 0 ok, 2 failed, 3 busy
    logic                              in_progress;
    logic                              done;       // Ack seen, result not collected
    logic                              bus_req;
    logic                              bus_rw;
    logic [dtm_pkg::dmi_abits-1:0]     bus_addr;
    logic [31:0]                       bus_wdata;
    logic                              upd_dmi;
    logic                              cap_dmi;
    logic                              accept;
    logic                              busy_evt;
    logic                              cap_done;
    logic                              ack_hit;

    //------------------------------------------------------------------
    // Command decode
    //------------------------------------------------------------------
    assign upd_dmi  = dr_sel.sel_dmi & dr_ctl.update;
    assign cap_dmi  = dr_sel.sel_dmi & dr_ctl.capture;
    assign accept   = upd_dmi & (dmi_sr.req.op != dtm_pkg::dmi_op_nop)
                    & (status == dtm_pkg::dmi_resp_ok) & ~in_progress;
    // Update while pending, or capture before the result is back
    assign busy_evt = in_progress & (upd_dmi | (cap_dmi & ~done));
    assign cap_done = cap_dmi & in_progress & done;
    assign ack_hit  = bus_req & dmbus_rsp.ack;

    // Capture value; sticky status wins over any result
    always_comb
    begin
        cap_word = '0;
        if (status != dtm_pkg::dmi_resp_ok)
            cap_word.resp = status;
        else if (busy_evt)
            cap_word.resp = dtm_pkg::dmi_resp_busy;
        else if (cap_done)
            cap_word = rsp_latch;
    end

    //------------------------------------------------------------------
    // DMI shift register
    //------------------------------------------------------------------
    always_ff @(posedge tck)
    begin
        if (cap_dmi)
            dmi_sr.resp <= cap_word;
        else if (dr_sel.sel_dmi && dr_ctl.shift)
            dmi_sr <= {dr_ctl.tdi, dmi_sr[dtm_pkg::dmi_word_width-1:1]};
    end

    assign tdo_dmi = dmi_sr[0];

    //------------------------------------------------------------------
    // Control state
    //------------------------------------------------------------------
    always_ff @(posedge tck or posedge res_tap_async)
    begin
        if (res_tap_async)
        begin
            in_progress <= 1'b0;
            done        <= 1'b0;
            status      <= dtm_pkg::dmi_resp_ok;
            bus_req     <= 1'b0;
        end
        else if (dmihardreset)
        begin
            in_progress <= 1'b0;                 // Also drops a pending req
            done        <= 1'b0;
            status      <= dtm_pkg::dmi_resp_ok;
            bus_req     <= 1'b0;
        end
        else
        begin
            if (accept)
                in_progress <= 1'b1;
            else if (cap_done || (dmireset && done))
                in_progress <= 1'b0;             // Result collected or dropped

            if (accept)
                done <= 1'b0;
            else if (ack_hit)
                done <= 1'b1;

            // Sticky until dmireset
            if (dmireset)
                status <= dtm_pkg::dmi_resp_ok;
            else if (status == dtm_pkg::dmi_resp_ok)
            begin
                if (busy_evt)
                    status <= dtm_pkg::dmi_resp_busy;
                else if (cap_done && rsp_latch.resp == dtm_pkg::dmi_resp_failed)
                    status <= dtm_pkg::dmi_resp_failed;
            end

            if (accept)
                bus_req <= 1'b1;                 // One TCK after Update-DR
            else if (ack_hit)
                bus_req <= 1'b0;
        end
    end

    //------------------------------------------------------------------
    // Bus payload and response latch
    //------------------------------------------------------------------
    always_ff @(posedge tck)
    begin
        if (accept)
        begin
            bus_rw    <= (dmi_sr.req.op == dtm_pkg::dmi_op_write);
            bus_addr  <= dmi_sr.req.addr;
            bus_wdata <= dmi_sr.req.data;
        end
        if (ack_hit)
        begin
            rsp_latch.addr <= bus_addr;
            rsp_latch.data <= bus_rw ? bus_wdata : dmbus_rsp.rdata; // Write echoes wdata
            rsp_latch.resp <= dmbus_rsp.err ? dtm_pkg::dmi_resp_failed
                                            : dtm_pkg::dmi_resp_ok;
        end
    end

    assign dmbus_req = '{req: bus_req, rw: bus_rw, addr: bus_addr, wdata: bus_wdata};
    assign dmistat   = status;

endmodule

//--- source/dtm_jtag_top.sv
// JTAG DTM top level joining TAP controller, DTM registers and DMI access
`timescale 1ns/1ps

module dtm_jtag_top
#(
    parameter logic [31:0] idcode_value = 32'h1000_0a6d,
    parameter logic [2:0]  idle_hint    = 3'd5
)
(
    input  logic                tck,
    input  logic                res_tap_async,
    input  logic                tms,
    input  logic                tdi,
    output logic                tdo_d,
    output logic                tdo_e,
    output dtm_pkg::dmbus_req_t dmbus_req,
    input  dtm_pkg::dmbus_rsp_t dmbus_rsp
);

    dtm_pkg::dr_ctl_t dr_ctl;
    dtm_pkg::dr_sel_t dr_sel;
    logic             tdo_regs;
    logic             tdo_dmi;
    logic             dmireset;
    logic             dmihardreset;
    logic [1:0]       dmistat;

    jtag_tap_ctrl u_tap
    (
        .tck           (tck),
        .res_tap_async (res_tap_async),
        .tms           (tms),
        .tdi           (tdi),
        .tdo_regs      (tdo_regs),
        .tdo_dmi       (tdo_dmi),
        .dr_ctl        (dr_ctl),
        .dr_sel        (dr_sel),
        .tdo_d         (tdo_d),
        .tdo_e         (tdo_e)
    );

    dtm_regs #(.idcode_value(idcode_value), .idle_hint(idle_hint)) u_regs
    (
        .tck           (tck),
        .res_tap_async (res_tap_async),
        .dr_ctl        (dr_ctl),
        .dr_sel        (dr_sel),
        .dmistat       (dmistat),
        .tdo_regs      (tdo_regs),
        .dmireset      (dmireset),
        .dmihardreset  (dmihardreset)
    );

    dmi_access u_dmi
    (
        .tck           (tck),
        .res_tap_async (res_tap_async),
        .dr_ctl        (dr_ctl),
        .dr_sel        (dr_sel),
        .dmireset      (dmireset),
        .dmihardreset  (dmihardreset),
        .dmistat       (dmistat),
        .tdo_dmi       (tdo_dmi),
        .dmbus_req     (dmbus_req),
        .dmbus_rsp     (dmbus_rsp)
    );

endmodule

//--- dv/tb_dtm_jtag.sv
// Testbench for the JTAG DTM: clock, reset, TAP scan tasks, debug-module model, checks
`timescale 1ns/1ps

module tb_dtm_jtag;

    localparam logic [31:0] idcode_exp = 32'h1000_0a6d;
    localparam logic [2:0]  hint_exp   = 3'd5;
    // Roughly 40 scans of under 60 cycles plus bus waits, far below this
    localparam int          cycle_limit = 20000;

    logic                tck;
    logic                res_tap_async;
    logic                tms;
    logic                tdi;
    logic                tdo_d;
    logic                tdo_e;
    dtm_pkg::dmbus_req_t dmbus_req;
    dtm_pkg::dmbus_rsp_t dmbus_rsp;

    logic [31:0] mem [0:127];   // Debug-module word space
    logic [2:0]  wait_cnt;
    logic        model_busy;
    logic        hold_ack;      // Back-pressure switch
    integer      seed;
    int          cycles;
    string       test_name;
    logic        exp_rw;        // Expected bus payload while req is high
    logic [6:0]  exp_addr;
    logic [31:0] exp_wdata;
    logic [63:0] dout;

    dtm_jtag_top #(.idcode_value(idcode_exp), .idle_hint(hint_exp)) dut_i
    (
        .tck           (tck),
        .res_tap_async (res_tap_async),
        .tms           (tms),
        .tdi           (tdi),
        .tdo_d         (tdo_d),
        .tdo_e         (tdo_e),
        .dmbus_req     (dmbus_req),
        .dmbus_rsp     (dmbus_rsp)
    );

    always #4 tck = ~tck;   // 8 ns period

    //------------------------------------------------------------------
    // Checking and timeout
    //------------------------------------------------------------------
    task automatic check_value(input string what, input logic [63:0] exp, input logic [63:0] act);
        assert (exp === act)
        else
        begin
            $display("CHECK FAILED %s / %s: expected %h actual %h", test_name, what, exp, act);
            $display("sim failed");
            $fatal(1);
        end
    endtask

    always @(posedge tck)
    begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit)
        begin
            $display("Timeout: run did not finish within %0d TCK cycles", cycle_limit);
            $display("sim failed");
            $fatal(1);
        end
    end

    // Payload must hold steady for the whole request
    always @(posedge tck)
    begin
        if (!res_tap_async && dmbus_req.req)
        begin
            check_value("bus rw", 64'(exp_rw), 64'(dmbus_req.rw));
            check_value("bus addr", 64'(exp_addr), 64'(dmbus_req.addr));
            check_value("bus wdata", 64'(exp_wdata), 64'(dmbus_req.wdata));
        end
    end

    //------------------------------------------------------------------
    // Debug-module model, random ack delay, err at 0x7f
    //------------------------------------------------------------------
    always @(posedge tck)
    begin
        dmbus_rsp.ack <= 1'b0;
        dmbus_rsp.err <= 1'b0;
        if (model_busy && !dmbus_req.req)
            model_busy <= 1'b0;                         // Request dropped by hard reset
        else if (dmbus_req.req && !model_busy && !dmbus_rsp.ack)
        begin
            model_busy <= 1'b1;
            wait_cnt   <= 3'(({$random(seed)} % 6) + 1);
        end
        else if (model_busy && !hold_ack)
        begin
            if (wait_cnt <= 3'd1)
            begin
                dmbus_rsp.ack   <= 1'b1;
                dmbus_rsp.err   <= (dmbus_req.addr == 7'h7f);
                dmbus_rsp.rdata <= mem[dmbus_req.addr];
                if (dmbus_req.rw)
                    mem[dmbus_req.addr] <= dmbus_req.wdata;
                model_busy <= 1'b0;
            end
            else
                wait_cnt <= wait_cnt - 3'd1;
        end
    end

    //------------------------------------------------------------------
    // JTAG tasks
    //------------------------------------------------------------------
    // TDO sampled at the edge, new TMS/TDI take effect at the next one
    task automatic step(input logic tms_v, input logic tdi_v, output logic tdo_v);
        @(posedge tck);
        tdo_v = tdo_d;
        tms <= tms_v;
        tdi <= tdi_v;
    endtask

    // Idle to Idle scan, LSB first
    task automatic scan(input logic is_ir, input int n, input logic [63:0] din,
                        output logic [63:0] dq);
        logic o;
        dq = '0;
        step(1'b1, 1'b0, o);
        if (is_ir)
            step(1'b1, 1'b0, o);
        step(1'b0, 1'b0, o);                            // To Capture
        step(1'b0, 1'b0, o);                            // To Shift
        for (int i = 0; i < n; i++)
        begin
            step(i == n - 1, din[i], o);
            if (i > 0)
            begin
                dq[i-1] = o;
                check_value("tdo_e in shift", 64'd1, 64'(tdo_e));
            end
        end
        step(1'b1, 1'b0, o);                            // Exit1 to Update
        dq[n-1] = o;
        step(1'b0, 1'b0, o);                            // Update to Idle
    endtask

    task automatic wait_ack();
        do
            @(posedge tck);
        while (!dmbus_rsp.ack);
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge tck);
    endtask

    // Issue one DMI op and set the expected bus payload
    task automatic dmi_issue(input logic [6:0] a, input logic [31:0] d, input logic [1:0] op);
        logic [63:0] q;
        exp_rw    = (op == 2'd2);
        exp_addr  = a;
        exp_wdata = d;
        scan(1'b0, 41, 64'({a, d, op}), q);
    endtask

    // Nop scan that collects the last result
    task automatic dmi_collect(input logic [6:0] a, input logic [31:0] d, input logic [1:0] rsp);
        logic [63:0] q;
        scan(1'b0, 41, 64'({7'h00, 32'h0, 2'd0}), q);
        check_value("resp", 64'(rsp), 64'(q[1:0]));
        check_value("data", 64'(d), 64'(q[33:2]));
        check_value("addr", 64'(a), 64'(q[40:34]));
    endtask

    task automatic dtmcs_scan(input logic [31:0] din, input logic [1:0] stat);
        logic [63:0] q;
        scan(1'b0, 32, 64'(din), q);
        check_value("dtmcs", 64'({17'd0, hint_exp, stat, 6'd7, 4'd1}), q);
    endtask

    task automatic load_ir(input logic [4:0] code, input logic [4:0] prev);
        logic [63:0] q;
        scan(1'b1, 5, 64'(code), q);
        check_value("ir capture", 64'(prev), q);
    endtask

    //------------------------------------------------------------------
    // Stimulus
    //------------------------------------------------------------------
    initial
    begin
        tck           = 1'b0;
        res_tap_async = 1'b1;
        tms           = 1'b1;
        tdi           = 1'b0;
        dmbus_rsp     = '0;
        model_busy    = 1'b0;
        wait_cnt      = 3'd0;
        hold_ack      = 1'b0;
        seed          = 32'h93f0;
        cycles        = 0;
        exp_rw        = 1'b0;
        exp_addr      = '0;
        exp_wdata     = '0;
        for (int i = 0; i < 128; i++)
            mem[i] = 32'h5a00_0000 ^ {i[6:0], 8'h3c, i[6:0], 10'h155}; // Address-unique fill

        repeat (4) @(posedge tck);
        res_tap_async <= 1'b0;
        @(posedge tck);
        tms <= 1'b0;                                    // Leave Test-Logic-Reset
        wait_cycles(3);

        test_name = "idcode_after_reset";
        check_value("tdo_e idle", 64'd0, 64'(tdo_e));
        check_value("req idle", 64'd0, 64'(dmbus_req.req));
        scan(1'b0, 32, 64'h0, dout);
        check_value("idcode", 64'(idcode_exp), dout);
        check_value("tdo_e after scan", 64'd0, 64'(tdo_e));

        test_name = "ir_capture_bypass";
        load_ir(5'h1f, 5'h01);
        scan(1'b0, 9, 64'h0b6, dout);                   // Zero first, then input one bit late
        check_value("bypass delay", 64'({8'hb6, 1'b0}), 64'(dout[8:0]));

        test_name = "dtmcs_read";
        load_ir(5'h10, 5'h1f);
        dtmcs_scan(32'h0, 2'd0);

        test_name = "dmi_write_read";
        load_ir(5'h11, 5'h10);
        dmi_issue(7'h12, 32'hcafe_1234, 2'd2);
        wait_ack();
        dmi_collect(7'h12, 32'hcafe_1234, 2'd0);
        dmi_issue(7'h12, 32'h0, 2'd1);
        wait_ack();
        dmi_collect(7'h12, 32'hcafe_1234, 2'd0);
        dmi_issue(7'h7f, 32'h0, 2'd1);
        wait_ack();
        dmi_collect(7'h7f, mem[7'h7f], 2'd2);
        load_ir(5'h10, 5'h11);
        dtmcs_scan(32'h1 << 16, 2'd2);                  // Failed is sticky, clear it
        dtmcs_scan(32'h0, 2'd0);

        test_name = "dmi_busy";
        load_ir(5'h11, 5'h10);
        hold_ack <= 1'b1;
        dmi_issue(7'h21, 32'h0, 2'd1);
        scan(1'b0, 41, 64'({7'h21, 32'h0, 2'd1}), dout); // Second op while pending
        check_value("busy resp", 64'd3, 64'(dout[1:0]));
        dmi_collect(7'h00, 32'h0, 2'd3);
        hold_ack <= 1'b0;
        wait_ack();
        load_ir(5'h10, 5'h11);
        dtmcs_scan(32'h1 << 16, 2'd3);
        dtmcs_scan(32'h0, 2'd0);
        load_ir(5'h11, 5'h10);
        dmi_issue(7'h33, 32'h0bad_f00d, 2'd2);
        wait_ack();
        dmi_collect(7'h33, 32'h0bad_f00d, 2'd0);
        dmi_issue(7'h33, 32'h0, 2'd1);
        wait_ack();
        dmi_collect(7'h33, 32'h0bad_f00d, 2'd0);

        test_name = "dmi_hard_reset";
        hold_ack <= 1'b1;
        dmi_issue(7'h44, 32'h1111_2222, 2'd2);
        wait_cycles(2);
        check_value("req pending", 64'd1, 64'(dmbus_req.req));
        scan(1'b0, 41, 64'({7'h44, 32'h1111_2222, 2'd2}), dout); // Sets sticky busy
        load_ir(5'h10, 5'h11);
        dtmcs_scan(32'h1 << 17, 2'd3);
        wait_cycles(3);                                 // Pulse, then req clear
        check_value("req dropped", 64'd0, 64'(dmbus_req.req));
        dtmcs_scan(32'h0, 2'd0);
        hold_ack <= 1'b0;
        wait_cycles(4);

        $display("sim passed");
        $finish;
    end

endmodule

//--- sim.f
source/dtm_pkg.sv
source/jtag_tap_ctrl.sv
source/dtm_regs.sv
source/dmi_access.sv
source/dtm_jtag_top.sv
dv/tb_dtm_jtag.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the DTM testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f --top-module tb_dtm_jtag -o tb_dtm_jtag
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/tb_dtm_jtag)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "sim passed" <<< "$output"; then
    exit 0
fi
exit 1
